//--- Makefile
VERILATOR ?= verilator
TOP ?= armExecPipeTb
LOG ?= sim.log

OBJ_DIR := obj_dir

.PHONY: sim clean

# pass or fail is taken from the log, not from the exit status
sim:
	$(VERILATOR) --binary --assert -f armExecPipe.f --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- armExecPipe.f
common/isaPkg.sv
common/pipePkg.sv
source/instrDecoder.sv
source/registerFile.sv
source/deReg.sv
execute/barrelShifter.sv
execute/alu.sv
execute/condUnit.sv
execute/executeStage.sv
source/armExecPipe.sv
tests/clockGen.sv
tests/armExecPipeTb.sv

//--- common/isaPkg.sv
`default_nettype none

package isaPkg;

    localparam int DataWidth = 32;
    localparam int RegAddrWidth = 4;

    // cond field, bits 31:28
    typedef enum logic [3:0] {
        EQ = 4'h0, NE = 4'h1, CS = 4'h2, CC = 4'h3,
        MI = 4'h4, PL = 4'h5, VS = 4'h6, VC = 4'h7,
        HI = 4'h8, LS = 4'h9, GE = 4'hA, LT = 4'hB,
        GT = 4'hC, LE = 4'hD, AL = 4'hE
    } condCode_e;

    // opcode field, bits 24:21
    typedef enum logic [3:0] {
        DpAnd = 4'h0, DpEor = 4'h1, DpSub = 4'h2, DpRsb = 4'h3,
        DpAdd = 4'h4, DpAdc = 4'h5, DpSbc = 4'h6, DpRsc = 4'h7,
        DpTst = 4'h8, DpTeq = 4'h9, DpCmp = 4'hA, DpCmn = 4'hB,
        DpOrr = 4'hC, DpMov = 4'hD, DpBic = 4'hE, DpMvn = 4'hF
    } dpOpcode_e;

    typedef enum logic [1:0] {
        LSL = 2'b00,
        LSR = 2'b01,
        ASR = 2'b10,
        ROR = 2'b11
    } shiftType_e;

endpackage

`default_nettype wire

//--- common/pipePkg.sv
`default_nettype none

package pipePkg;

    // compare and test opcodes reuse these
    typedef enum logic [3:0] {
        AluAnd,
        AluEor,
        AluSub,
        AluRsb,
        AluAdd,
        AluAdc,
        AluSbc,
        AluOrr,
        AluMov,
        AluBic,
        AluMvn
    } aluOp_e;

    // bit positions in FlagW
    localparam int FlagWNZ = 1;
    localparam int FlagWCV = 0;

endpackage

`default_nettype wire

//--- execute/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input wire [isaPkg::DataWidth-1:0] SrcA,
    input wire [isaPkg::DataWidth-1:0] SrcB,
    input wire pipePkg::aluOp_e AluOp,
    input wire CarryIn,
    input wire ShiftCarry,
    output logic [isaPkg::DataWidth-1:0] Result,
    output logic [3:0] AluFlags
);

    import isaPkg::*;
    import pipePkg::*;

    localparam int Msb = DataWidth - 1;

    logic [DataWidth-1:0] addA;
    logic [DataWidth-1:0] addB;
    logic addCin;
    logic isArith;
    logic [DataWidth:0] sum;
    logic overflow;

    // all arithmetic goes through one adder
    always_comb begin
        addA = SrcA;
        addB = SrcB;
        addCin = 1'b0;
        isArith = 1'b1;
        case (AluOp)
            AluAdd: addCin = 1'b0;
            AluAdc: addCin = CarryIn;
            AluSub: begin
                addB = ~SrcB;
                addCin = 1'b1;
            end
            AluSbc: begin
                addB = ~SrcB;
                addCin = CarryIn;
            end
            AluRsb: begin
                addA = SrcB;
                addB = ~SrcA;
                addCin = 1'b1;
            end
            default: isArith = 1'b0;
        endcase
    end

    assign sum = {1'b0, addA} + {1'b0, addB} + {{DataWidth{1'b0}}, addCin};
    assign overflow = (addA[Msb] == addB[Msb]) && (sum[Msb] != addA[Msb]);

    always_comb begin
        case (AluOp)
            AluAnd: Result = SrcA & SrcB;
            AluEor: Result = SrcA ^ SrcB;
            AluOrr: Result = SrcA | SrcB;
            AluMov: Result = SrcB;
            AluBic: Result = SrcA & ~SrcB;
            AluMvn: Result = ~SrcB;
            default: Result = sum[Msb:0];
        endcase
    end

    // V is written only for arithmetic ops, so logical ones leave it as stored
    assign AluFlags = {Result[Msb], Result == '0, isArith ? sum[DataWidth] : ShiftCarry,
                       isArith && overflow};

endmodule

`default_nettype wire

//--- execute/barrelShifter.sv
`timescale 1ns/100ps
`default_nettype none

module barrelShifter (
    input wire [isaPkg::DataWidth-1:0] Value,
    input wire isaPkg::shiftType_e ShType,
    input wire [4:0] Shamt5,
    input wire CarryIn,
    output logic [isaPkg::DataWidth-1:0] Shifted,
    output logic ShiftCarry
);

    import isaPkg::*;

    always_comb begin
        Shifted = Value;
        ShiftCarry = CarryIn;  // zero amount, no shift for any type
        if (Shamt5 != 5'd0) begin
            case (ShType)
                LSL: {ShiftCarry, Shifted} = {1'b0, Value} << Shamt5;
                LSR: {Shifted, ShiftCarry} = {Value, 1'b0} >> Shamt5;
                ASR: {Shifted, ShiftCarry} = $signed({Value, 1'b0}) >>> Shamt5;
                ROR: begin
                    Shifted = (Value >> Shamt5) | (Value << (DataWidth - Shamt5));
                    ShiftCarry = Shifted[DataWidth-1];
                end
                default: Shifted = Value;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- execute/condUnit.sv
`timescale 1ns/100ps
`default_nettype none

module condUnit (
    input wire CLK,
    input wire Reset,
    input wire Stall,
    input wire isaPkg::condCode_e CondE,
    input wire [1:0] FlagWE,
    input wire [3:0] AluFlags,
    output logic CondExE,
    output logic [3:0] Flags
);

    import isaPkg::*;
    import pipePkg::*;

    logic n;
    logic z;
    logic c;
    logic v;

    assign {n, z, c, v} = Flags;

    always_comb begin
        case (CondE)
            EQ: CondExE = z;
            NE: CondExE = !z;
            CS: CondExE = c;
            CC: CondExE = !c;
            MI: CondExE = n;
            PL: CondExE = !n;
            VS: CondExE = v;
            VC: CondExE = !v;
            HI: CondExE = c && !z;
            LS: CondExE = !c || z;
            GE: CondExE = (n == v);
            LT: CondExE = (n != v);
            GT: CondExE = !z && (n == v);
            LE: CondExE = z || (n != v);
            AL: CondExE = 1'b1;
            default: CondExE = 1'b0;  // 4'hF never executes
        endcase
    end

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            Flags <= 4'b0000;
        end else if (!Stall && CondExE) begin
            if (FlagWE[FlagWNZ]) begin
                Flags[3:2] <= AluFlags[3:2];
            end
            if (FlagWE[FlagWCV]) begin
                Flags[1:0] <= AluFlags[1:0];
            end
        end
    end

    flagsHeld: assert property (@(posedge CLK) disable iff (Reset)
        (FlagWE == 2'b00) |=> $stable(Flags));

endmodule

`default_nettype wire

//--- execute/executeStage.sv
`timescale 1ns/100ps
`default_nettype none

module executeStage (
    input wire CLK,
    input wire Reset,
    input wire Stall,
    input wire isaPkg::condCode_e CondE,
    input wire [1:0] FlagWE,
    input wire RegWE,
    input wire [isaPkg::RegAddrWidth-1:0] WA3E,
    input wire ALUSrcE,
    input wire pipePkg::aluOp_e ALUControlE,
    input wire [isaPkg::RegAddrWidth-1:0] RA1E,
    input wire [isaPkg::RegAddrWidth-1:0] RA2E,
    input wire [isaPkg::DataWidth-1:0] RD1E,
    input wire [isaPkg::DataWidth-1:0] RD2E,
    input wire [isaPkg::DataWidth-1:0] ExtImmE,
    input wire isaPkg::shiftType_e ShE,
    input wire [4:0] Shamt5E,
    input wire NoWriteE,
    output logic [isaPkg::DataWidth-1:0] ResultW,
    output logic [isaPkg::RegAddrWidth-1:0] WA3W,
    output logic RegWriteW,
    output logic [3:0] Flags
);

    import isaPkg::*;

    logic [DataWidth-1:0] srcA;
    logic [DataWidth-1:0] regB;
    logic [DataWidth-1:0] shiftIn;
    logic [DataWidth-1:0] srcB;
    logic [DataWidth-1:0] aluResult;
    logic [3:0] aluFlags;
    logic shiftCarry;
    logic condEx;

    // forward the result sitting in writeback
    assign srcA = (RegWriteW && WA3W == RA1E) ? ResultW : RD1E;
    assign regB = (RegWriteW && WA3W == RA2E) ? ResultW : RD2E;
    assign shiftIn = ALUSrcE ? ExtImmE : regB;

    barrelShifter i_shifter (
        .Value(shiftIn),
        .ShType(ShE),
        .Shamt5(Shamt5E),
        .CarryIn(Flags[1]),  // stored C
        .Shifted(srcB),
        .ShiftCarry(shiftCarry)
    );

    alu i_alu (
        .SrcA(srcA),
        .SrcB(srcB),
        .AluOp(ALUControlE),
        .CarryIn(Flags[1]),
        .ShiftCarry(shiftCarry),
        .Result(aluResult),
        .AluFlags(aluFlags)
    );

    condUnit i_cond (
        .CLK(CLK),
        .Reset(Reset),
        .Stall(Stall),
        .CondE(CondE),
        .FlagWE(FlagWE),
        .AluFlags(aluFlags),
        .CondExE(condEx),
        .Flags(Flags)
    );

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            RegWriteW <= 1'b0;
        end else if (!Stall) begin
            RegWriteW <= RegWE && condEx && !NoWriteE;
        end
    end

    always_ff @(posedge CLK) begin
        if (!Stall) begin
            ResultW <= aluResult;
            WA3W <= WA3E;
        end
    end

endmodule

`default_nettype wire

//--- source/armExecPipe.sv
`timescale 1ns/100ps
`default_nettype none

module armExecPipe (
    input wire CLK,
    input wire Reset,
    input wire [isaPkg::DataWidth-1:0] Instr,
    input wire Stall,
    input wire Flush,
    output logic [isaPkg::DataWidth-1:0] ResultW,
    output logic [isaPkg::RegAddrWidth-1:0] WA3W,
    output logic RegWriteW,
    output logic [3:0] Flags
);

    import isaPkg::*;
    import pipePkg::*;

    // decode side
    condCode_e CondD;
    logic [1:0] FlagWD;
    logic RegWD;
    logic [RegAddrWidth-1:0] WA3D;
    logic ALUSrcD;
    aluOp_e ALUControlD;
    logic [RegAddrWidth-1:0] RA1D;
    logic [RegAddrWidth-1:0] RA2D;
    logic [DataWidth-1:0] RD1D;
    logic [DataWidth-1:0] RD2D;
    logic [DataWidth-1:0] ExtImmD;
    shiftType_e ShD;
    logic [4:0] Shamt5D;
    logic NoWriteD;

    // execute side
    condCode_e CondE;
    logic [1:0] FlagWE;
    logic RegWE;
    logic [RegAddrWidth-1:0] WA3E;
    logic ALUSrcE;
    aluOp_e ALUControlE;
    logic [RegAddrWidth-1:0] RA1E;
    logic [RegAddrWidth-1:0] RA2E;
    logic [DataWidth-1:0] RD1E;
    logic [DataWidth-1:0] RD2E;
    logic [DataWidth-1:0] ExtImmE;
    shiftType_e ShE;
    logic [4:0] Shamt5E;
    logic NoWriteE;

    logic deEn;
    logic regWriteEn;

    assign deEn = !Stall;
    assign regWriteEn = RegWriteW && !Stall;  // writes land only on moving edges

    instrDecoder i_decoder (.*);

    registerFile i_regFile (
        .CLK(CLK),
        .Reset(Reset),
        .RA1(RA1D),
        .RA2(RA2D),
        .WA3(WA3W),
        .WD3(ResultW),
        .WE3(regWriteEn),
        .RD1(RD1D),
        .RD2(RD2D)
    );

    deReg i_deReg (
        .EN(deEn),
        .CLR(Flush),
        .*
    );

    executeStage i_execute (.*);

endmodule

`default_nettype wire

//--- source/deReg.sv
`timescale 1ns/100ps
`default_nettype none

module deReg (
    input wire CLK,
    input wire Reset,
    input wire EN,
    input wire CLR,
    input wire isaPkg::condCode_e CondD,
    input wire [1:0] FlagWD,
    input wire RegWD,
    input wire [isaPkg::RegAddrWidth-1:0] WA3D,
    input wire ALUSrcD,
    input wire pipePkg::aluOp_e ALUControlD,
    input wire [isaPkg::RegAddrWidth-1:0] RA1D,
    input wire [isaPkg::RegAddrWidth-1:0] RA2D,
    input wire [isaPkg::DataWidth-1:0] RD1D,
    input wire [isaPkg::DataWidth-1:0] RD2D,
    input wire [isaPkg::DataWidth-1:0] ExtImmD,
    input wire isaPkg::shiftType_e ShD,
    input wire [4:0] Shamt5D,
    input wire NoWriteD,
    output isaPkg::condCode_e CondE,
    output logic [1:0] FlagWE,
    output logic RegWE,
    output logic [isaPkg::RegAddrWidth-1:0] WA3E,
    output logic ALUSrcE,
    output pipePkg::aluOp_e ALUControlE,
    output logic [isaPkg::RegAddrWidth-1:0] RA1E,
    output logic [isaPkg::RegAddrWidth-1:0] RA2E,
    output logic [isaPkg::DataWidth-1:0] RD1E,
    output logic [isaPkg::DataWidth-1:0] RD2E,
    output logic [isaPkg::DataWidth-1:0] ExtImmE,
    output isaPkg::shiftType_e ShE,
    output logic [4:0] Shamt5E,
    output logic NoWriteE
);

    import isaPkg::*;
    import pipePkg::*;

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            CondE <= EQ;
            FlagWE <= 2'b00;
            RegWE <= 1'b0;
            ALUSrcE <= 1'b0;
            ALUControlE <= AluAnd;
            ShE <= LSL;
            Shamt5E <= 5'd0;
            NoWriteE <= 1'b0;
        end else if (CLR || EN) begin  // clear wins over hold
            CondE <= CLR ? EQ : CondD;
            FlagWE <= CLR ? 2'b00 : FlagWD;
            RegWE <= CLR ? 1'b0 : RegWD;
            ALUSrcE <= CLR ? 1'b0 : ALUSrcD;
            ALUControlE <= CLR ? AluAnd : ALUControlD;
            ShE <= CLR ? LSL : ShD;
            Shamt5E <= CLR ? 5'd0 : Shamt5D;
            NoWriteE <= CLR ? 1'b0 : NoWriteD;
        end
    end

    // operands and addresses
    always_ff @(posedge CLK) begin
        if (CLR || EN) begin
            WA3E <= CLR ? '0 : WA3D;
            RA1E <= CLR ? '0 : RA1D;
            RA2E <= CLR ? '0 : RA2D;
            RD1E <= CLR ? '0 : RD1D;
            RD2E <= CLR ? '0 : RD2D;
            ExtImmE <= CLR ? '0 : ExtImmD;
        end
    end

    // a flushed slot reaches execute as a bubble
    flushIsBubble: assert property (@(posedge CLK) disable iff (Reset)
        CLR |=> (RegWE == 1'b0 && FlagWE == 2'b00));

endmodule

`default_nettype wire

//--- source/instrDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module instrDecoder (
    input wire [isaPkg::DataWidth-1:0] Instr,
    output isaPkg::condCode_e CondD,
    output logic [1:0] FlagWD,
    output logic RegWD,
    output logic [isaPkg::RegAddrWidth-1:0] WA3D,
    output logic ALUSrcD,
    output pipePkg::aluOp_e ALUControlD,
    output logic [isaPkg::RegAddrWidth-1:0] RA1D,
    output logic [isaPkg::RegAddrWidth-1:0] RA2D,
    output logic [isaPkg::DataWidth-1:0] ExtImmD,
    output isaPkg::shiftType_e ShD,
    output logic [4:0] Shamt5D,
    output logic NoWriteD
);

    import isaPkg::*;
    import pipePkg::*;

    dpOpcode_e opcode;
    logic isDp;
    logic legalOp;
    logic isArith;
    logic [DataWidth-1:0] imm8;
    logic [4:0] rotAmt;

    assign opcode = dpOpcode_e'(Instr[24:21]);
    // bit 4 set on a register operand means a register-specified shift
    assign isDp = (Instr[27:26] == 2'b00) && (Instr[25] || !Instr[4]);
    assign legalOp = (opcode != DpRsc);
    assign imm8 = {{(DataWidth - 8){1'b0}}, Instr[7:0]};
    assign rotAmt = {Instr[11:8], 1'b0};  // twice the rot field

    assign CondD = condCode_e'(Instr[31:28]);
    assign RA1D = Instr[19:16];
    assign RA2D = Instr[3:0];
    assign WA3D = Instr[15:12];
    assign ALUSrcD = Instr[25];
    assign ExtImmD = (imm8 >> rotAmt) | (imm8 << (DataWidth - rotAmt));
    assign ShD = Instr[25] ? LSL : shiftType_e'(Instr[6:5]);
    assign Shamt5D = Instr[25] ? 5'd0 : Instr[11:7];  // immediate passes shifter as is

    always_comb begin
        case (opcode)
            DpAnd, DpTst: ALUControlD = AluAnd;
            DpEor, DpTeq: ALUControlD = AluEor;
            DpSub, DpCmp: ALUControlD = AluSub;
            DpRsb: ALUControlD = AluRsb;
            DpAdd, DpCmn: ALUControlD = AluAdd;
            DpAdc: ALUControlD = AluAdc;
            DpSbc: ALUControlD = AluSbc;
            DpOrr: ALUControlD = AluOrr;
            DpMov: ALUControlD = AluMov;
            DpBic: ALUControlD = AluBic;
            DpMvn: ALUControlD = AluMvn;
            default: ALUControlD = AluAnd;  // RSC, not decoded
        endcase
    end

    assign isArith = ALUControlD inside {AluSub, AluRsb, AluAdd, AluAdc, AluSbc};
    assign NoWriteD = opcode inside {DpTst, DpTeq, DpCmp, DpCmn};

    // R15 is never a destination
    assign RegWD = isDp && legalOp && !NoWriteD && (WA3D != '1);
    assign FlagWD[FlagWNZ] = isDp && legalOp && Instr[20];
    assign FlagWD[FlagWCV] = isDp && legalOp && Instr[20] && isArith;

endmodule

`default_nettype wire

//--- source/registerFile.sv
`timescale 1ns/100ps
`default_nettype none

module registerFile (
    input wire CLK,
    input wire Reset,
    input wire [isaPkg::RegAddrWidth-1:0] RA1,
    input wire [isaPkg::RegAddrWidth-1:0] RA2,
    input wire [isaPkg::RegAddrWidth-1:0] WA3,
    input wire [isaPkg::DataWidth-1:0] WD3,
    input wire WE3,
    output logic [isaPkg::DataWidth-1:0] RD1,
    output logic [isaPkg::DataWidth-1:0] RD2
);

    import isaPkg::*;

    localparam int NumRegs = 15;  // R0..R14

    logic [DataWidth-1:0] regs [NumRegs];

    function automatic logic [DataWidth-1:0] readPort(input logic [RegAddrWidth-1:0] addr);
        if (addr == '1) begin
            return '0;  // R15 reads zero
        end else if (WE3 && addr == WA3) begin
            return WD3;  // write-through
        end
        return regs[addr];
    endfunction

    always_comb begin
        RD1 = readPort(RA1);
        RD2 = readPort(RA2);
    end

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (WE3) begin
            regs[WA3] <= WD3;
        end
    end

    // decoder never lets R15 through as a destination
    noR15Write: assert property (@(posedge CLK) disable iff (Reset) WE3 |-> (WA3 != '1));

endmodule

`default_nettype wire

//--- tests/armExecPipeTb.sv
`timescale 1ns/100ps
`default_nettype none

module armExecPipeTb;

    import isaPkg::*;

    localparam int MaxRows = 64;
    localparam int DrainSteps = 2;  // lets the last row reach writeback and write
    localparam logic [DataWidth-1:0] Nop = 32'h0C00_0000;  // not data processing

    logic CLK;
    logic Reset;
    logic [DataWidth-1:0] Instr;
    logic Stall;
    logic Flush;
    logic [DataWidth-1:0] ResultW;
    logic [RegAddrWidth-1:0] WA3W;
    logic RegWriteW;
    logic [3:0] Flags;

    // stimulus table
    string rowName [MaxRows];
    logic [DataWidth-1:0] rowInstr [MaxRows];
    logic rowStall [MaxRows];
    logic rowFlush [MaxRows];
    logic rowWrite [MaxRows];
    logic [RegAddrWidth-1:0] rowReg [MaxRows];
    logic [DataWidth-1:0] rowValue [MaxRows];
    logic [3:0] rowFlags [MaxRows];
    int numRows;

    // row index held in deReg and in writeback, -1 for a bubble
    int exSlot;
    int wbSlot;
    logic [3:0] lastFlags;

    int errorCount;
    int checkCount;
    int writesSeen;
    int writesExpected;
    int cycleCount;
    int cycleLimit;

    clockGen i_clock (
        .CLK(CLK),
        .Reset(Reset)
    );

    armExecPipe i_dut (.*);

    function automatic logic [DataWidth-1:0] dpImm(input condCode_e cond, input dpOpcode_e op,
            input logic s, input logic [3:0] rn, input logic [3:0] rd, input logic [3:0] rot,
            input logic [7:0] imm);
        return {cond, 2'b00, 1'b1, op, s, rn, rd, rot, imm};
    endfunction

    function automatic logic [DataWidth-1:0] dpReg(input condCode_e cond, input dpOpcode_e op,
            input logic s, input logic [3:0] rn, input logic [3:0] rd, input logic [4:0] shamt,
            input shiftType_e sh, input logic [3:0] rm);
        return {cond, 2'b00, 1'b0, op, s, rn, rd, shamt, sh, 1'b0, rm};
    endfunction

    task automatic addRow(input string name, input logic [DataWidth-1:0] instr,
            input logic stall, input logic flush, input logic write,
            input logic [RegAddrWidth-1:0] rd, input logic [DataWidth-1:0] value,
            input logic [3:0] nzcv);
        rowName[numRows] = name;
        rowInstr[numRows] = instr;
        rowStall[numRows] = stall;
        rowFlush[numRows] = flush;
        rowWrite[numRows] = write;
        rowReg[numRows] = rd;
        rowValue[numRows] = value;
        rowFlags[numRows] = nzcv;
        numRows++;
    endtask

    task automatic expectWrite(input string name, input logic [DataWidth-1:0] instr,
            input logic [RegAddrWidth-1:0] rd, input logic [DataWidth-1:0] value,
            input logic [3:0] nzcv);
        addRow(name, instr, 1'b0, 1'b0, 1'b1, rd, value, nzcv);
    endtask

    task automatic expectNoWrite(input string name, input logic [DataWidth-1:0] instr,
            input logic [3:0] nzcv);
        addRow(name, instr, 1'b0, 1'b0, 1'b0, 4'd0, '0, nzcv);
    endtask

    task automatic stallRow(input string name, input logic [DataWidth-1:0] instr);
        addRow(name, instr, 1'b1, 1'b0, 1'b0, 4'd0, '0, 4'b0000);
    endtask

    task automatic flushRow(input string name, input logic [DataWidth-1:0] instr);
        addRow(name, instr, 1'b0, 1'b1, 1'b0, 4'd0, '0, 4'b0000);
    endtask

    task automatic buildTable();
        numRows = 0;
        // immediates and rotations
        expectWrite("mov r0 imm", dpImm(AL, DpMov, 1'b0, 4'd0, 4'd0, 4'h0, 8'h12),
                    4'd0, 32'h0000_0012, 4'b0000);
        expectWrite("mov r1 rot8", dpImm(AL, DpMov, 1'b0, 4'd0, 4'd1, 4'h4, 8'hFF),
                    4'd1, 32'hFF00_0000, 4'b0000);
        expectWrite("mov r2 rot2", dpImm(AL, DpMov, 1'b0, 4'd0, 4'd2, 4'h1, 8'h03),
                    4'd2, 32'hC000_0000, 4'b0000);
        expectWrite("mov r3 rot30", dpImm(AL, DpMov, 1'b0, 4'd0, 4'd3, 4'hF, 8'h81),
                    4'd3, 32'h0000_0204, 4'b0000);
        // register operands, forwarding and write-through
        expectWrite("add fwd", dpReg(AL, DpAdd, 1'b0, 4'd0, 4'd4, 5'd0, LSL, 4'd3),
                    4'd4, 32'h0000_0216, 4'b0000);
        expectWrite("sub lsl4", dpReg(AL, DpSub, 1'b0, 4'd4, 4'd5, 5'd4, LSL, 4'd0),
                    4'd5, 32'h0000_00F6, 4'b0000);
        expectWrite("rsb through", dpReg(AL, DpRsb, 1'b0, 4'd4, 4'd6, 5'd1, LSL, 4'd0),
                    4'd6, 32'hFFFF_FE0E, 4'b0000);
        expectWrite("and lsr4", dpReg(AL, DpAnd, 1'b0, 4'd1, 4'd7, 5'd4, LSR, 4'd2),
                    4'd7, 32'h0C00_0000, 4'b0000);
        expectWrite("eor asr8", dpReg(AL, DpEor, 1'b0, 4'd7, 4'd8, 5'd8, ASR, 4'd1),
                    4'd8, 32'hF3FF_0000, 4'b0000);
        expectWrite("orr ror4", dpReg(AL, DpOrr, 1'b0, 4'd0, 4'd9, 5'd4, ROR, 4'd3),
                    4'd9, 32'h4000_0032, 4'b0000);
        expectWrite("bic asr0", dpReg(AL, DpBic, 1'b0, 4'd8, 4'd10, 5'd0, ASR, 4'd2),
                    4'd10, 32'h33FF_0000, 4'b0000);
        expectWrite("mvn lsr0", dpReg(AL, DpMvn, 1'b0, 4'd0, 4'd11, 5'd0, LSR, 4'd0),
                    4'd11, 32'hFFFF_FFED, 4'b0000);
        // flags
        expectNoWrite("cmp neg", dpReg(AL, DpCmp, 1'b1, 4'd0, 4'd0, 5'd0, LSL, 4'd3), 4'b1000);
        expectNoWrite("cmp pos", dpReg(AL, DpCmp, 1'b1, 4'd3, 4'd0, 5'd0, LSL, 4'd0), 4'b0010);
        expectNoWrite("cmn carry", dpReg(AL, DpCmn, 1'b1, 4'd1, 4'd0, 5'd0, LSL, 4'd1), 4'b1010);
        expectNoWrite("tst zero", dpReg(AL, DpTst, 1'b1, 4'd7, 4'd0, 5'd0, LSL, 4'd0), 4'b0110);
        expectNoWrite("teq", dpReg(AL, DpTeq, 1'b1, 4'd2, 4'd0, 5'd0, LSL, 4'd1), 4'b0010);
        expectWrite("adds carry", dpReg(AL, DpAdd, 1'b1, 4'd2, 4'd12, 5'd0, LSL, 4'd2),
                    4'd12, 32'h8000_0000, 4'b1010);
        expectWrite("adc c1", dpReg(AL, DpAdc, 1'b0, 4'd0, 4'd13, 5'd0, LSL, 4'd0),
                    4'd13, 32'h0000_0025, 4'b1010);
        expectWrite("subs zero", dpReg(AL, DpSub, 1'b1, 4'd0, 4'd14, 5'd0, LSL, 4'd0),
                    4'd14, 32'h0000_0000, 4'b0110);
        expectWrite("sbc c1", dpReg(AL, DpSbc, 1'b0, 4'd3, 4'd13, 5'd0, LSL, 4'd0),
                    4'd13, 32'h0000_01F2, 4'b0110);
        expectWrite("adds ovf", dpReg(AL, DpAdd, 1'b1, 4'd12, 4'd12, 5'd0, LSL, 4'd12),
                    4'd12, 32'h0000_0000, 4'b0111);
        expectWrite("sbcs borrow", dpReg(AL, DpSbc, 1'b1, 4'd0, 4'd11, 5'd0, LSL, 4'd3),
                    4'd11, 32'hFFFF_FE0E, 4'b1000);
        expectWrite("adc c0", dpReg(AL, DpAdc, 1'b0, 4'd0, 4'd10, 5'd0, LSL, 4'd0),
                    4'd10, 32'h0000_0024, 4'b1000);
        // conditions
        expectNoWrite("cmp equal", dpReg(AL, DpCmp, 1'b1, 4'd0, 4'd0, 5'd0, LSL, 4'd0), 4'b0110);
        expectWrite("moveq taken", dpImm(EQ, DpMov, 1'b0, 4'd0, 4'd5, 4'h0, 8'h55),
                    4'd5, 32'h0000_0055, 4'b0110);
        expectNoWrite("movne skip", dpImm(NE, DpMov, 1'b0, 4'd0, 4'd6, 4'h0, 8'h66), 4'b0110);
        expectNoWrite("cmp less", dpReg(AL, DpCmp, 1'b1, 4'd0, 4'd0, 5'd0, LSL, 4'd3), 4'b1000);
        expectNoWrite("addsge skip", dpReg(GE, DpAdd, 1'b1, 4'd0, 4'd7, 5'd0, LSL, 4'd0),
                      4'b1000);
        expectWrite("movlt taken", dpImm(LT, DpMov, 1'b0, 4'd0, 4'd7, 4'h0, 8'h77),
                    4'd7, 32'h0000_0077, 4'b1000);
        expectNoWrite("cmp higher", dpReg(AL, DpCmp, 1'b1, 4'd3, 4'd0, 5'd0, LSL, 4'd0), 4'b0010);
        expectWrite("movhi taken", dpImm(HI, DpMov, 1'b0, 4'd0, 4'd8, 4'h0, 8'h88),
                    4'd8, 32'h0000_0088, 4'b0010);
        expectNoWrite("subseq skip", dpReg(EQ, DpSub, 1'b1, 4'd8, 4'd8, 5'd0, LSL, 4'd8),
                      4'b0010);
        expectWrite("add after skip", dpReg(AL, DpAdd, 1'b0, 4'd7, 4'd9, 5'd0, LSL, 4'd8),
                    4'd9, 32'h0000_00FF, 4'b0010);
        // stall and flush, the source holds Instr while stalled
        stallRow("stall mov", dpImm(AL, DpMov, 1'b0, 4'd0, 4'd0, 4'h0, 8'h01));
        expectWrite("mov after stall", dpImm(AL, DpMov, 1'b0, 4'd0, 4'd0, 4'h0, 8'h01),
                    4'd0, 32'h0000_0001, 4'b0010);
        stallRow("stall add 1", dpReg(AL, DpAdd, 1'b0, 4'd0, 4'd1, 5'd0, LSL, 4'd0));
        stallRow("stall add 2", dpReg(AL, DpAdd, 1'b0, 4'd0, 4'd1, 5'd0, LSL, 4'd0));
        expectWrite("add after stall", dpReg(AL, DpAdd, 1'b0, 4'd0, 4'd1, 5'd0, LSL, 4'd0),
                    4'd1, 32'h0000_0002, 4'b0010);
        flushRow("flushed movs", dpImm(AL, DpMov, 1'b1, 4'd0, 4'd2, 4'h0, 8'h99));
        expectWrite("add after flush", dpReg(AL, DpAdd, 1'b0, 4'd1, 4'd3, 5'd0, LSL, 4'd2),
                    4'd3, 32'hC000_0002, 4'b0010);
        expectNoWrite("cmp then stall", dpReg(AL, DpCmp, 1'b1, 4'd3, 4'd0, 5'd0, LSL, 4'd0),
                      4'b1010);
        stallRow("stall movs", dpImm(AL, DpMov, 1'b1, 4'd0, 4'd4, 4'h0, 8'h00));
        expectWrite("movs zero", dpImm(AL, DpMov, 1'b1, 4'd0, 4'd4, 4'h0, 8'h00),
                    4'd4, 32'h0000_0000, 4'b0110);
    endtask

    task automatic checkWrite(input string testName, input logic [RegAddrWidth-1:0] expReg,
            input logic [DataWidth-1:0] expValue);
        checkCount++;
        if (WA3W !== expReg || ResultW !== expValue) begin
            errorCount++;
            $display("[FAIL] %s: expected R%0d = %h, actual R%0d = %h",
                     testName, expReg, expValue, WA3W, ResultW);
        end
    endtask

    task automatic checkFlags(input string testName, input logic [3:0] expFlags);
        checkCount++;
        if (Flags !== expFlags) begin
            errorCount++;
            $display("[FAIL] %s: expected NZCV %b, actual NZCV %b", testName, expFlags, Flags);
        end
    endtask

    // compares the writeback outputs with the row the model holds there
    task automatic inspectWriteback();
        string stageName;
        stageName = "bubble";
        if (wbSlot >= 0) begin
            stageName = rowName[wbSlot];
            lastFlags = rowFlags[wbSlot];
            if (rowWrite[wbSlot] && RegWriteW) begin
                checkWrite(stageName, rowReg[wbSlot], rowValue[wbSlot]);
            end else if (rowWrite[wbSlot]) begin
                errorCount++;
                $display("%s: write strobe is missing in writeback", stageName);
            end else if (RegWriteW) begin
                errorCount++;
                $display("%s: write strobe is set for an instruction that writes nothing",
                         stageName);
            end
        end else if (RegWriteW) begin
            errorCount++;
            $display("write strobe is set while a bubble sits in writeback");
        end
        checkFlags(stageName, lastFlags);
    endtask

    // drives one cycle and advances the reference pipeline past the next edge
    task automatic applyStep(input int rowIdx);
        logic stall;
        logic flush;
        stall = (rowIdx >= 0) ? rowStall[rowIdx] : 1'b0;
        flush = (rowIdx >= 0) ? rowFlush[rowIdx] : 1'b0;
        Instr = (rowIdx >= 0) ? rowInstr[rowIdx] : Nop;
        Stall = stall;
        Flush = flush;
        if (RegWriteW && !stall) begin
            writesSeen++;  // lands on the coming edge
        end
        if (!stall) begin
            wbSlot = exSlot;
            if (wbSlot >= 0 && rowWrite[wbSlot]) begin
                writesExpected++;
            end
            exSlot = flush ? -1 : rowIdx;
        end else if (flush) begin
            exSlot = -1;
        end
    endtask

    initial begin
        Instr = Nop;
        Stall = 1'b0;
        Flush = 1'b0;
        errorCount = 0;
        checkCount = 0;
        writesSeen = 0;
        writesExpected = 0;
        cycleCount = 0;
        exSlot = -1;
        wbSlot = -1;
        lastFlags = 4'b0000;  // flags clear after reset
        buildTable();
        cycleLimit = numRows + 20;
        @(negedge Reset);
        for (int step = 0; step < numRows + DrainSteps; step++) begin
            if (step > 0) begin
                @(negedge CLK);
            end
            inspectWriteback();
            applyStep(step < numRows ? step : -1);
        end
        if (writesSeen != writesExpected) begin
            errorCount++;
            $display("register file received %0d writes but %0d were expected",
                     writesSeen, writesExpected);
        end
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    always @(posedge CLK) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Errors found");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tests/clockGen.sv
`timescale 1ns/100ps
`default_nettype none

module clockGen (
    output logic CLK,
    output logic Reset
);

    localparam real HalfPeriod = 5.0;  // 10 ns period
    localparam int ResetCycles = 4;

    initial begin
        CLK = 1'b0;
        forever #HalfPeriod CLK = ~CLK;
    end

    initial begin
        Reset = 1'b1;
        repeat (ResetCycles) @(posedge CLK);
        @(negedge CLK);
        Reset = 1'b0;  // released on a falling edge
    end

endmodule

`default_nettype wire
